//--- filelist.f
+incdir+verilog
verilog/rtx_pkg.sv
verilog/ray_caster.sv
verilog/scene_buffer.sv
verilog/ray_tracer.sv
verilog/pixel_convert.sv
verilog/rtx.sv
tests/rtx_chk.sv
tests/rtx_tb.sv

//--- Makefile
TOOL       := verilator
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
TOP        := rtx_tb
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(TOOL) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "make sim: passed"; \
	else \
		echo "make sim: failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/rtx_trace.txt
# S index cx cy z rad red green blue last   (colours as fp24 hex words)
# P h v rgb565   (expected pixels of one frame in raster order)
S 0 1 1 50 1 3f0000 be0000 000000 0
S 1 2 2 30 1 3e0000 3e0000 3e0000 0
S 2 6 1 20 1 000000 400000 3e8000 0
S 3 5 2 20 1 3d0000 3d0000 3d0000 1
P 0 0 0000
P 1 0 001f
P 2 0 0000
P 3 0 0000
P 4 0 0000
P 5 0 0000
P 6 0 c7e0
P 7 0 0000
P 0 1 001f
P 1 1 001f
P 2 1 8410
P 3 1 0000
P 4 1 0000
P 5 1 c7e0
P 6 1 c7e0
P 7 1 c7e0
P 0 2 0000
P 1 2 8410
P 2 2 8410
P 3 2 8410
P 4 2 4208
P 5 2 4208
P 6 2 c7e0
P 7 2 0000
P 0 3 0000
P 1 3 0000
P 2 3 8410
P 3 3 0000
P 4 3 0000
P 5 3 4208
P 6 3 0000
P 7 3 0000

//--- tests/rtx_tb.sv
`include "rtx_defs.svh"

module rtx_tb;
  import rtx_pkg::*;

  localparam int    RESET_CYCLES = 16;
  localparam string TRACE_FILE   = "tests/rtx_trace.txt";

  logic                  clk;
  logic                  rst;
  logic                  scene_we;
  logic [`OBJ_IDX_W-1:0] scene_addr;
  logic [`H_W-1:0]       scene_cx;
  logic [`V_W-1:0]       scene_cy;
  logic [`Z_W-1:0]       scene_z;
  logic [`R_W-1:0]       scene_rad;
  fp24_t                 scene_red;
  fp24_t                 scene_green;
  fp24_t                 scene_blue;
  logic                  scene_last;
  logic [15:0]           rtx_pixel;
  logic [`H_W-1:0]       pixel_h;
  logic [`V_W-1:0]       pixel_v;
  logic                  pixel_valid;

  // Sphere records from the trace
  logic [`OBJ_IDX_W-1:0] sph_addr [$];
  logic [`H_W-1:0]       sph_cx [$];
  logic [`V_W-1:0]       sph_cy [$];
  logic [`Z_W-1:0]       sph_z [$];
  logic [`R_W-1:0]       sph_rad [$];
  logic [23:0]           sph_red [$];
  logic [23:0]           sph_green [$];
  logic [23:0]           sph_blue [$];
  logic                  sph_last [$];

  // Expected pixels in raster order
  logic [`H_W-1:0]       exp_h [$];
  logic [`V_W-1:0]       exp_v [$];
  logic [15:0]           exp_pix [$];

  int cycles;
  int cycle_limit;

  always #5 clk = ~clk;

  rtx dut0 (
    .clk(clk), .rst(rst),
    .scene_we(scene_we), .scene_addr(scene_addr),
    .scene_cx(scene_cx), .scene_cy(scene_cy), .scene_z(scene_z), .scene_rad(scene_rad),
    .scene_red(scene_red), .scene_green(scene_green), .scene_blue(scene_blue),
    .scene_last(scene_last),
    .rtx_pixel(rtx_pixel), .pixel_h(pixel_h), .pixel_v(pixel_v), .pixel_valid(pixel_valid)
  );

  bind rtx rtx_chk chk0 (
    .clk(clk), .rst(rst), .pixel_valid(pixel_valid), .pixel_h(pixel_h), .pixel_v(pixel_v)
  );

  task automatic stop_with_fail(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic read_trace();
    int                    fd;
    int                    ch;
    int                    n;
    logic [7:0]            c;
    logic [`OBJ_IDX_W-1:0] addr;
    logic [`H_W-1:0]       h;
    logic [`V_W-1:0]       v;
    logic [`Z_W-1:0]       z;
    logic [`R_W-1:0]       rad;
    logic [23:0]           red;
    logic [23:0]           green;
    logic [23:0]           blue;
    logic                  last;
    logic [15:0]           pix;
    fd = $fopen(TRACE_FILE, "r");
    assert (fd != 0) else stop_with_fail("cannot open the trace file");
    ch = $fgetc(fd);
    while (ch >= 0) begin
      c = ch[7:0];
      if (c == "#") begin
        // Comment runs to the end of the line
        while (ch >= 0 && ch[7:0] != "\n") begin
          ch = $fgetc(fd);
        end
      end else if (c == "S") begin
        n = $fscanf(fd, "%d %d %d %d %d %h %h %h %d",
                    addr, h, v, z, rad, red, green, blue, last);
        assert (n == 9) else stop_with_fail("malformed sphere record in the trace file");
        sph_addr.push_back(addr);
        sph_cx.push_back(h);
        sph_cy.push_back(v);
        sph_z.push_back(z);
        sph_rad.push_back(rad);
        sph_red.push_back(red);
        sph_green.push_back(green);
        sph_blue.push_back(blue);
        sph_last.push_back(last);
      end else if (c == "P") begin
        n = $fscanf(fd, "%d %d %h", h, v, pix);
        assert (n == 3) else stop_with_fail("malformed pixel record in the trace file");
        exp_h.push_back(h);
        exp_v.push_back(v);
        exp_pix.push_back(pix);
      end
      ch = $fgetc(fd);
    end
    $fclose(fd);
    assert (sph_addr.size() > 0 && sph_addr.size() <= `SCENE_DEPTH)
      else stop_with_fail("trace file holds no scene or too many spheres");
    assert (exp_h.size() > 0) else stop_with_fail("trace file holds no expected pixels");
  endtask

  // Scene goes in while reset is still high
  task automatic load_scene_in_reset();
    for (int c = 0; c < RESET_CYCLES - 1; c++) begin
      @(negedge clk);
      if (c < sph_addr.size()) begin
        scene_we        <= 1'b1;
        scene_addr      <= sph_addr[c];
        scene_cx        <= sph_cx[c];
        scene_cy        <= sph_cy[c];
        scene_z         <= sph_z[c];
        scene_rad       <= sph_rad[c];
        scene_red.raw   <= sph_red[c];
        scene_green.raw <= sph_green[c];
        scene_blue.raw  <= sph_blue[c];
        scene_last      <= sph_last[c];
      end else begin
        scene_we <= 1'b0;
      end
    end
    @(negedge clk);
    scene_we <= 1'b0;
    rst      <= 1'b0;
  endtask

  task automatic check_frame();
    for (int k = 0; k < exp_h.size(); k++) begin
      // Outputs are stable at the falling edge
      @(negedge clk);
      while (!pixel_valid) begin
        @(negedge clk);
      end
      assert (pixel_h == exp_h[k] && pixel_v == exp_v[k])
        else stop_with_fail($sformatf("Fail at time %0t: pixel %0d at (%0d,%0d), expected (%0d,%0d)",
                                      $time, k, pixel_h, pixel_v, exp_h[k], exp_v[k]));
      assert (rtx_pixel == exp_pix[k])
        else stop_with_fail($sformatf("Fail at time %0t: pixel (%0d,%0d) is %04h, expected %04h",
                                      $time, pixel_h, pixel_v, rtx_pixel, exp_pix[k]));
    end
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      stop_with_fail("timeout: pixels missing");
    end
  end

  initial begin
    clk             = 1'b0;
    rst             = 1'b1;
    scene_we        = 1'b0;
    scene_addr      = '0;
    scene_cx        = '0;
    scene_cy        = '0;
    scene_z         = '0;
    scene_rad       = '0;
    scene_red.raw   = '0;
    scene_green.raw = '0;
    scene_blue.raw  = '0;
    scene_last      = 1'b0;
    cycles          = 0;
    cycle_limit     = 0;

    read_trace();
    cycle_limit = (exp_h.size() + 2) * (`SCENE_DEPTH + 4) + RESET_CYCLES;
    load_scene_in_reset();
    check_frame();

    if (dut0.chk0.errors == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      stop_with_fail($sformatf("property checker counted %0d failures", dut0.chk0.errors));
    end
  end

endmodule

//--- tests/rtx_chk.sv
`include "rtx_defs.svh"

module rtx_chk #(
  parameter int WIDTH  = `RTX_WIDTH,
  parameter int HEIGHT = `RTX_HEIGHT
) (
  input logic            clk,
  input logic            rst,
  input logic            pixel_valid,
  input logic [`H_W-1:0] pixel_h,
  input logic [`V_W-1:0] pixel_v
);

  // Failed property count
  int unsigned errors = 0;

  // No pixel while reset is held
  quiet_in_reset: assert property (@(posedge clk) (rst && $past(rst)) |-> !pixel_valid)
    else begin
      $error("pixel_valid high during reset");
      errors++;
    end

  coord_in_frame: assert property (@(posedge clk) disable iff (rst)
      pixel_valid |-> (pixel_h < `H_W'(WIDTH)) && (pixel_v < `V_W'(HEIGHT)))
    else begin
      $error("pixel coordinate outside the frame");
      errors++;
    end

  // One tracer runs at a time, so pulses never touch
  single_pulse: assert property (@(posedge clk) disable iff (rst) pixel_valid |=> !pixel_valid)
    else begin
      $error("pixel_valid high on two cycles in a row");
      errors++;
    end

endmodule

//--- verilog/rtx.sv
`include "rtx_defs.svh"

module rtx #(
  parameter int WIDTH  = `RTX_WIDTH,
  parameter int HEIGHT = `RTX_HEIGHT
) (
  input  logic                  clk,
  input  logic                  rst,

  input  logic                  scene_we,
  input  logic [`OBJ_IDX_W-1:0] scene_addr,
  input  logic [`H_W-1:0]       scene_cx,
  input  logic [`V_W-1:0]       scene_cy,
  input  logic [`Z_W-1:0]       scene_z,
  input  logic [`R_W-1:0]       scene_rad,
  input  rtx_pkg::fp24_t        scene_red,
  input  rtx_pkg::fp24_t        scene_green,
  input  rtx_pkg::fp24_t        scene_blue,
  input  logic                  scene_last,

  output logic [15:0]           rtx_pixel,
  output logic [`H_W-1:0]       pixel_h,
  output logic [`V_W-1:0]       pixel_v,
  output logic                  pixel_valid
);
  import rtx_pkg::*;

  logic                  rst_prev;
  logic                  new_ray;
  logic [`H_W-1:0]       ray_h;
  logic [`V_W-1:0]       ray_v;
  logic                  ray_valid;
  logic [`OBJ_IDX_W-1:0] obj_idx;
  logic [`H_W-1:0]       obj_cx;
  logic [`V_W-1:0]       obj_cy;
  logic [`Z_W-1:0]       obj_z;
  logic [`R_W-1:0]       obj_rad;
  fp24_t                 obj_red;
  fp24_t                 obj_green;
  fp24_t                 obj_blue;
  logic                  obj_last;
  logic                  trace_done;
  fp24_t                 hit_red;
  fp24_t                 hit_green;
  fp24_t                 hit_blue;
  logic [`H_W-1:0]       done_h;
  logic [`V_W-1:0]       done_v;

  always_ff @(posedge clk) begin
    rst_prev <= rst;
  end

  // First ray on reset release, then one per finished pixel
  assign new_ray = (!rst && rst_prev) || trace_done;

  ray_caster #(.WIDTH(WIDTH), .HEIGHT(HEIGHT)) caster (
    .clk(clk), .rst(rst), .new_ray(new_ray),
    .ray_h(ray_h), .ray_v(ray_v), .ray_valid(ray_valid)
  );

  scene_buffer scene (
    .clk(clk), .rst(rst),
    .scene_we(scene_we), .scene_addr(scene_addr),
    .scene_cx(scene_cx), .scene_cy(scene_cy), .scene_z(scene_z), .scene_rad(scene_rad),
    .scene_red(scene_red), .scene_green(scene_green), .scene_blue(scene_blue),
    .scene_last(scene_last),
    .obj_idx(obj_idx), .obj_cx(obj_cx), .obj_cy(obj_cy), .obj_z(obj_z), .obj_rad(obj_rad),
    .obj_red(obj_red), .obj_green(obj_green), .obj_blue(obj_blue), .obj_last(obj_last)
  );

  ray_tracer tracer (
    .clk(clk), .rst(rst),
    .ray_h(ray_h), .ray_v(ray_v), .ray_valid(ray_valid),
    .obj_idx(obj_idx), .obj_cx(obj_cx), .obj_cy(obj_cy), .obj_z(obj_z), .obj_rad(obj_rad),
    .obj_red(obj_red), .obj_green(obj_green), .obj_blue(obj_blue), .obj_last(obj_last),
    .trace_done(trace_done), .hit_red(hit_red), .hit_green(hit_green), .hit_blue(hit_blue),
    .done_h(done_h), .done_v(done_v)
  );

  // fp24 colour to RGB565
  pixel_convert convert (
    .clk(clk), .rst(rst),
    .hit_red(hit_red), .hit_green(hit_green), .hit_blue(hit_blue),
    .trace_done(trace_done), .done_h(done_h), .done_v(done_v),
    .rtx_pixel(rtx_pixel), .pixel_h(pixel_h), .pixel_v(pixel_v), .pixel_valid(pixel_valid)
  );

endmodule

//--- verilog/pixel_convert.sv
`include "rtx_defs.svh"

module pixel_convert (
  input  logic            clk,
  input  logic            rst,
  input  rtx_pkg::fp24_t  hit_red,
  input  rtx_pkg::fp24_t  hit_green,
  input  rtx_pkg::fp24_t  hit_blue,
  input  logic            trace_done,
  input  logic [`H_W-1:0] done_h,
  input  logic [`V_W-1:0] done_v,
  output logic [15:0]     rtx_pixel,
  output logic [`H_W-1:0] pixel_h,
  output logic [`V_W-1:0] pixel_v,
  output logic            pixel_valid
);
  import rtx_pkg::*;

  // Negative goes to 0, anything at or above 1.0 becomes 1.0
  function automatic fp24_t clip_unit(input fp24_t x);
    fp24_t y;
    y = x;
    if (x.f.sign) begin
      y.raw = '0;
    end else if (int'(x.f.exp) >= FP24_BIAS) begin
      y.raw = FP24_ONE;
    end
    return y;
  endfunction

  // floor(x * 2^k), saturated to k bits
  function automatic logic [6:0] to_fixed(input fp24_t x, input int k);
    logic [16:0] sig;
    logic [16:0] q;
    int          sh;
    sig = {1'b1, x.f.mant};
    sh  = FP24_BIAS + 16 - k - int'(x.f.exp);
    q   = sig >> sh;
    if (q > 17'((1 << k) - 1)) begin
      q = 17'((1 << k) - 1);
    end
    return q[6:0];
  endfunction

  fp24_t           s1_red;
  fp24_t           s1_green;
  fp24_t           s1_blue;
  logic            s1_valid;
  logic [`H_W-1:0] s1_h;
  logic [`V_W-1:0] s1_v;

  logic [6:0] r_fix;
  logic [6:0] g_fix;
  logic [6:0] b_fix;

  assign r_fix = to_fixed(s1_red, 5);
  assign g_fix = to_fixed(s1_green, 6);
  assign b_fix = to_fixed(s1_blue, 5);

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid    <= 1'b0;
      pixel_valid <= 1'b0;
    end else begin
      s1_valid    <= trace_done;
      pixel_valid <= s1_valid;
    end
  end

  // Stage 1 clip, stage 2 pack
  always_ff @(posedge clk) begin
    s1_red    <= clip_unit(hit_red);
    s1_green  <= clip_unit(hit_green);
    s1_blue   <= clip_unit(hit_blue);
    s1_h      <= done_h;
    s1_v      <= done_v;
    rtx_pixel <= {b_fix[4:0], g_fix[5:0], r_fix[4:0]};
    pixel_h   <= s1_h;
    pixel_v   <= s1_v;
  end

endmodule

//--- verilog/ray_tracer.sv
`include "rtx_defs.svh"

module ray_tracer (
  input  logic                  clk,
  input  logic                  rst,

  input  logic [`H_W-1:0]       ray_h,
  input  logic [`V_W-1:0]       ray_v,
  input  logic                  ray_valid,

  // Scene memory, data lags obj_idx by one cycle
  output logic [`OBJ_IDX_W-1:0] obj_idx,
  input  logic [`H_W-1:0]       obj_cx,
  input  logic [`V_W-1:0]       obj_cy,
  input  logic [`Z_W-1:0]       obj_z,
  input  logic [`R_W-1:0]       obj_rad,
  input  rtx_pkg::fp24_t        obj_red,
  input  rtx_pkg::fp24_t        obj_green,
  input  rtx_pkg::fp24_t        obj_blue,
  input  logic                  obj_last,

  output logic                  trace_done,
  output rtx_pkg::fp24_t        hit_red,
  output rtx_pkg::fp24_t        hit_green,
  output rtx_pkg::fp24_t        hit_blue,
  output logic [`H_W-1:0]       done_h,
  output logic [`V_W-1:0]       done_v
);
  import rtx_pkg::*;

  localparam int D_W = 2 * `H_W + 3;

  logic            walking;
  logic [`H_W-1:0] ray_h_q;
  logic [`V_W-1:0] ray_v_q;

  // Disc test on the current memory word
  logic signed [`H_W:0]  dx;
  logic signed [`V_W:0]  dy;
  logic [2*`H_W+1:0]     dx_sq;
  logic [2*`V_W+1:0]     dy_sq;
  logic [2*`R_W-1:0]     rad_sq;
  logic [D_W-1:0]        dist_sq;

  // Stage A, one sphere tested
  logic            a_valid;
  logic            a_hit;
  logic            a_last;
  logic [`Z_W-1:0] a_z;
  fp24_t           a_red;
  fp24_t           a_green;
  fp24_t           a_blue;

  // Nearest hit so far
  logic            best_found;
  logic [`Z_W-1:0] best_z;
  fp24_t           best_red;
  fp24_t           best_green;
  fp24_t           best_blue;
  logic            take;

  assign dx      = $signed({1'b0, ray_h_q}) - $signed({1'b0, obj_cx});
  assign dy      = $signed({1'b0, ray_v_q}) - $signed({1'b0, obj_cy});
  assign dx_sq   = dx * dx;
  assign dy_sq   = dy * dy;
  assign rad_sq  = obj_rad * obj_rad;
  assign dist_sq = D_W'(dx_sq) + D_W'(dy_sq);

  // Strict less-than keeps the lower index on a depth tie
  assign take = a_valid && a_hit && (!best_found || (a_z < best_z));

  // Object walk
  always_ff @(posedge clk) begin
    if (rst) begin
      walking <= 1'b0;
      obj_idx <= '0;
    end else if (ray_valid) begin
      // Object 0 is already being read
      walking <= 1'b1;
      obj_idx <= `OBJ_IDX_W'(1);
    end else if (walking) begin
      if (obj_last) begin
        walking <= 1'b0;
        obj_idx <= '0;
      end else begin
        obj_idx <= obj_idx + `OBJ_IDX_W'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ray_valid) begin
      ray_h_q <= ray_h;
      ray_v_q <= ray_v;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      a_valid    <= 1'b0;
      trace_done <= 1'b0;
      best_found <= 1'b0;
    end else begin
      a_valid    <= walking;
      trace_done <= a_valid && a_last;
      if (ray_valid) begin
        best_found <= 1'b0;
      end else if (take) begin
        best_found <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    // Edge of the disc counts as a hit
    a_hit   <= (dist_sq <= D_W'(rad_sq));
    a_last  <= obj_last;
    a_z     <= obj_z;
    a_red   <= obj_red;
    a_green <= obj_green;
    a_blue  <= obj_blue;

    if (take) begin
      best_z     <= a_z;
      best_red   <= a_red;
      best_green <= a_green;
      best_blue  <= a_blue;
    end

    // Result of the last sphere folds in directly
    if (a_valid && a_last) begin
      done_h <= ray_h_q;
      done_v <= ray_v_q;
      if (take) begin
        hit_red   <= a_red;
        hit_green <= a_green;
        hit_blue  <= a_blue;
      end else if (best_found) begin
        hit_red   <= best_red;
        hit_green <= best_green;
        hit_blue  <= best_blue;
      end else begin
        hit_red   <= '0;
        hit_green <= '0;
        hit_blue  <= '0;
      end
    end
  end

endmodule

//--- verilog/scene_buffer.sv
`include "rtx_defs.svh"

module scene_buffer (
  input  logic                  clk,
  input  logic                  rst,

  // Scene load port
  input  logic                  scene_we,
  input  logic [`OBJ_IDX_W-1:0] scene_addr,
  input  logic [`H_W-1:0]       scene_cx,
  input  logic [`V_W-1:0]       scene_cy,
  input  logic [`Z_W-1:0]       scene_z,
  input  logic [`R_W-1:0]       scene_rad,
  input  rtx_pkg::fp24_t        scene_red,
  input  rtx_pkg::fp24_t        scene_green,
  input  rtx_pkg::fp24_t        scene_blue,
  input  logic                  scene_last,

  // Tracer read port
  input  logic [`OBJ_IDX_W-1:0] obj_idx,
  output logic [`H_W-1:0]       obj_cx,
  output logic [`V_W-1:0]       obj_cy,
  output logic [`Z_W-1:0]       obj_z,
  output logic [`R_W-1:0]       obj_rad,
  output rtx_pkg::fp24_t        obj_red,
  output rtx_pkg::fp24_t        obj_green,
  output rtx_pkg::fp24_t        obj_blue,
  output logic                  obj_last
);
  import rtx_pkg::*;

  logic [`H_W-1:0] mem_cx    [`SCENE_DEPTH];
  logic [`V_W-1:0] mem_cy    [`SCENE_DEPTH];
  logic [`Z_W-1:0] mem_z     [`SCENE_DEPTH];
  logic [`R_W-1:0] mem_rad   [`SCENE_DEPTH];
  fp24_t           mem_red   [`SCENE_DEPTH];
  fp24_t           mem_green [`SCENE_DEPTH];
  fp24_t           mem_blue  [`SCENE_DEPTH];

  // Index of the final object in the scene
  logic [`OBJ_IDX_W-1:0] last_idx;

  // Loads are taken even while rst is high
  always_ff @(posedge clk) begin
    if (scene_we) begin
      mem_cx[scene_addr]    <= scene_cx;
      mem_cy[scene_addr]    <= scene_cy;
      mem_z[scene_addr]     <= scene_z;
      mem_rad[scene_addr]   <= scene_rad;
      mem_red[scene_addr]   <= scene_red;
      mem_green[scene_addr] <= scene_green;
      mem_blue[scene_addr]  <= scene_blue;
      if (scene_last) begin
        last_idx <= scene_addr;
      end
    end
  end

  // Registered read, one cycle behind obj_idx
  always_ff @(posedge clk) begin
    obj_cx    <= mem_cx[obj_idx];
    obj_cy    <= mem_cy[obj_idx];
    obj_z     <= mem_z[obj_idx];
    obj_rad   <= mem_rad[obj_idx];
    obj_red   <= mem_red[obj_idx];
    obj_green <= mem_green[obj_idx];
    obj_blue  <= mem_blue[obj_idx];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      obj_last <= 1'b0;
    end else begin
      obj_last <= (obj_idx == last_idx);
    end
  end

endmodule

//--- verilog/ray_caster.sv
`include "rtx_defs.svh"

module ray_caster #(
  parameter int WIDTH  = `RTX_WIDTH,
  parameter int HEIGHT = `RTX_HEIGHT
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              new_ray,
  output logic [`H_W-1:0]   ray_h,
  output logic [`V_W-1:0]   ray_v,
  output logic              ray_valid
);

  // Coordinate of the next ray to issue
  logic [`H_W-1:0] h_cnt;
  logic [`V_W-1:0] v_cnt;

  logic h_end;
  logic v_end;

  assign h_end = (h_cnt == `H_W'(WIDTH - 1));
  assign v_end = (v_cnt == `V_W'(HEIGHT - 1));

  // Raster counters, h first then v
  always_ff @(posedge clk) begin
    if (rst) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (new_ray) begin
      if (h_end) begin
        h_cnt <= '0;
        // Wrap to the top at frame end
        v_cnt <= v_end ? '0 : v_cnt + `V_W'(1);
      end else begin
        h_cnt <= h_cnt + `H_W'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ray_valid <= 1'b0;
    end else begin
      ray_valid <= new_ray;
    end
  end

  // Coordinate goes out with the valid pulse
  always_ff @(posedge clk) begin
    if (new_ray) begin
      ray_h <= h_cnt;
      ray_v <= v_cnt;
    end
  end

endmodule

//--- verilog/rtx_pkg.sv
package rtx_pkg;

  // Same word seen as raw bits or as decoded fields
  // fp24 layout: 1 sign, 7 exponent, 16 mantissa
  typedef union packed {
    logic [23:0] raw;
    struct packed {
      logic        sign;
      logic [6:0]  exp;
      logic [15:0] mant;
    } f;
  } fp24_t;

  // Exponent bias
  localparam int FP24_BIAS = 63;

  // 1.0 in fp24
  localparam logic [23:0] FP24_ONE = 24'h3f0000;

endpackage

//--- verilog/rtx_defs.svh
`ifndef RTX_DEFS_SVH
`define RTX_DEFS_SVH

// Frame size in pixels
`define RTX_WIDTH 8
`define RTX_HEIGHT 4

// Sphere slots in the scene memory
`define SCENE_DEPTH 8
`define OBJ_IDX_W 3

// Pixel coordinate widths
`define H_W 11
`define V_W 10

// Sphere geometry widths
`define Z_W 8
`define R_W 8

`endif
